// File: all.f
hw/sd_pkg.sv
hw/sd_cmd_rx.sv
hw/sd_cmd_ctrl.sv
hw/sd_resp_tx.sv
hw/sd_block_ram.sv
hw/sd_axil_regs.sv
hw/sd_spi_card.sv
dv/sd_spi_card_tb.sv

// File: dv/sd_spi_card_tb.sv
`timescale 1ns/1ps

module sd_spi_card_tb;
  import sd_pkg::*;

  // block reads include the aborted one and some margin.
  localparam int n_blk_reads = 10;
  localparam int spi_bits = n_blk_reads * 4400 + 60 * 200;
  localparam int bus_cycles = 1200 * 10;
  localparam int watchdog_ns = (spi_bits + bus_cycles) * 4 * 2;

  logic      sck;
  logic      rst;
  logic      cs;
  logic      mosi;
  logic      miso;
  axil_req_t req;
  axil_rsp_t rsp;

  logic [31:0] rng_state = 32'h24f2_0818;
  int          val_errs = 0;
  int          other_errs = 0;
  logic [7:0]  last_r1;

  // card model.
  logic [31:0] m_mem [512];
  logic        m_idle;
  logic        m_app;
  logic        m_seen;
  logic [7:0]  m_crc_errs;
  logic [15:0] m_reads;

  logic [5:0]  init_idx [6] = '{6'd0, 6'd8, 6'd55, 6'd41, 6'd55, 6'd41};
  logic [7:0]  init_r1 [6] = '{8'h01, 8'h01, 8'h01, 8'h01, 8'h01, 8'h00};

  sd_spi_card uut (
    .sck      (sck),
    .rst      (rst),
    .cs       (cs),
    .mosi     (mosi),
    .miso     (miso),
    .axil_req (req),
    .axil_rsp (rsp)
  );

  initial begin
    sck = 1'b0;
    forever #2 sck = ~sck;
  end

  function automatic logic [31:0] rand32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [6:0] crc7_of(input logic [39:0] bits);
    logic [6:0] r;
    logic       inb;
    r = 7'd0;
    for (int i = 39; i >= 0; i--) begin
      inb = bits[i] ^ r[6];
      r = r << 1;
      r[0] = inb;
      r[3] = r[3] ^ inb;
    end
    return r;
  endfunction

  function automatic logic [15:0] crc16_bit(input logic [15:0] c, input logic d);
    logic [15:0] r;
    logic        inb;
    inb = c[15] ^ d;
    r = c << 1;
    r[0] = inb;
    r[5] = r[5] ^ inb;
    r[12] = r[12] ^ inb;
    return r;
  endfunction

  task automatic val_err(input string name, input logic [31:0] got, input logic [31:0] exp);
    val_errs++;
    $display("ERR %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
  endtask

  task automatic other_err(input string msg);
    other_errs++;
    $display("failure: %s at %0t", msg, $time);
  endtask

  task automatic report_and_finish();
    $display("errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  initial begin
    #(watchdog_ns);
    other_err("watchdog expired before the tests finished");
    report_and_finish();
  end

  task automatic bus_write(input logic [11:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    int n;
    int hold;
    @(negedge sck);
    req.awvalid = 1'b1;
    req.awaddr = addr;
    req.wvalid = 1'b1;
    req.wdata = data;
    req.wstrb = strb;
    req.bready = 1'b0;
    n = 0;
    do begin
      @(negedge sck);
      n++;
    end while (rsp.bvalid !== 1'b1 && n < 20);
    req.awvalid = 1'b0;
    req.wvalid = 1'b0;
    if (rsp.bvalid !== 1'b1) begin
      other_err("write response never arrived");
    end else begin
      // bvalid must hold while B stalls.
      hold = rand32() % 3;
      repeat (hold) begin
        @(negedge sck);
        if (rsp.bvalid !== 1'b1) begin
          val_err("bvalid", rsp.bvalid, 1);
        end
      end
      if (rsp.bresp !== 2'b00) begin
        val_err("bresp", rsp.bresp, 0);
      end
      req.bready = 1'b1;
      @(negedge sck);
      req.bready = 1'b0;
    end
  endtask

  task automatic bus_read(input logic [11:0] addr, output logic [31:0] data);
    int n;
    @(negedge sck);
    req.arvalid = 1'b1;
    req.araddr = addr;
    req.rready = 1'b0;
    n = 0;
    do begin
      @(negedge sck);
      n++;
    end while (rsp.rvalid !== 1'b1 && n < 20);
    req.arvalid = 1'b0;
    data = rsp.rdata;
    if (rsp.rvalid !== 1'b1) begin
      other_err("read data never arrived");
    end else begin
      if (rsp.rresp !== 2'b00) begin
        val_err("rresp", rsp.rresp, 0);
      end
      req.rready = 1'b1;
      @(negedge sck);
      req.rready = 1'b0;
    end
  endtask

  task automatic check_status();
    logic [31:0] got;
    logic [31:0] exp;
    exp = {m_reads, m_crc_errs, 7'd0, !m_idle};
    bus_read(status_addr, got);
    if (got !== exp) begin
      val_err("status", got, exp);
    end
  endtask

  // applies the command rules to the model and predicts the answer.
  task automatic model_cmd(input logic [5:0] index, input logic [31:0] arg,
                           input logic crc_good, output logic [7:0] r1,
                           output logic [1:0] kind);
    logic app_was;
    kind = 2'd0;
    r1 = {7'd0, m_idle};
    if (!crc_good) begin
      r1 = 8'h08 | {7'd0, m_idle};
      if (m_crc_errs != 8'hFF) begin
        m_crc_errs = m_crc_errs + 8'd1;
      end
    end else begin
      app_was = m_app;
      m_app = 1'b0;
      if (index == cmd0) begin
        m_idle = 1'b1;
        m_seen = 1'b0;
        r1 = 8'h01;
      end else if (index == cmd8) begin
        kind = 2'd1;
      end else if (index == cmd55) begin
        m_app = 1'b1;
      end else if (index == cmd41 && app_was) begin
        if (!m_seen) begin
          m_seen = 1'b1;
          r1 = 8'h01;
        end else begin
          m_idle = 1'b0;
          r1 = 8'h00;
        end
      end else if (index == cmd17 && !m_idle) begin
        r1 = 8'h00;
        if (arg < 32'd4) begin
          kind = 2'd2;
          m_reads = m_reads + 16'd1;
        end else begin
          kind = 2'd3;
        end
      end else begin
        r1 = 8'h04 | {7'd0, m_idle};
      end
    end
  endtask

  task automatic send_frame(input logic [5:0] index, input logic [31:0] arg,
                            input logic bad_crc, input int nbits);
    logic [47:0] frame;
    logic [6:0]  crc;
    int          k;
    crc = crc7_of({2'b01, index, arg});
    if (bad_crc) begin
      k = rand32() % 7;
      crc[k] = ~crc[k];
    end
    frame = {2'b01, index, arg, crc, 1'b1};
    for (int i = 47; i > 47 - nbits; i--) begin
      @(negedge sck);
      mosi = frame[i];
    end
  endtask

  task automatic get_bit(output logic b);
    @(negedge sck);
    mosi = 1'b1;
    b = miso;
  endtask

  task automatic get_byte(output logic [7:0] v);
    logic b;
    for (int i = 7; i >= 0; i--) begin
      get_bit(b);
      v[i] = b;
    end
  endtask

  task automatic find_r1(output logic [7:0] r1, output logic found);
    logic b;
    found = 1'b0;
    r1 = 8'hFF;
    for (int i = 0; i < 32 && !found; i++) begin
      get_bit(b);
      if (b === 1'b0) begin
        found = 1'b1;
      end
    end
    if (found) begin
      r1[7] = 1'b0;
      for (int i = 6; i >= 0; i--) begin
        get_bit(b);
        r1[i] = b;
      end
    end else begin
      other_err("no R1 start bit seen on miso");
    end
  endtask

  task automatic run_cmd(input logic [5:0] index, input logic [31:0] arg, input logic bad_crc);
    logic [7:0]  exp_r1;
    logic [7:0]  r1;
    logic [7:0]  v;
    logic [7:0]  exp_b;
    logic [7:0]  exp_tok;
    logic [7:0]  hi;
    logic [1:0]  kind;
    logic        found;
    logic [31:0] tail;
    logic [15:0] crc;
    int          wa;
    model_cmd(index, arg, !bad_crc, exp_r1, kind);
    send_frame(index, arg, bad_crc, 48);
    find_r1(r1, found);
    last_r1 = r1;
    if (found) begin
      if (r1 !== exp_r1) begin
        val_err("r1", r1, exp_r1);
      end
      if (kind == 2'd1) begin
        tail = '0;
        for (int i = 0; i < 4; i++) begin
          get_byte(v);
          tail = {tail[23:0], v};
        end
        if (tail !== {20'd0, 4'h1, arg[7:0]}) begin
          val_err("r7 tail", tail, {20'd0, 4'h1, arg[7:0]});
        end
      end else if (kind >= 2'd2) begin
        v = 8'hFF;
        for (int i = 0; i < 8 && v === 8'hFF; i++) begin
          get_byte(v);
        end
        exp_tok = (kind == 2'd2) ? 8'hFE : 8'h08;
        if (v !== exp_tok) begin
          val_err("token", v, exp_tok);
        end else if (kind == 2'd2) begin
          crc = '0;
          for (int k = 0; k < 512; k++) begin
            wa = arg[1:0] * 128 + k / 4;
            exp_b = m_mem[wa][8*(k%4) +: 8];
            get_byte(v);
            if (v !== exp_b) begin
              val_err("data byte", v, exp_b);
            end
            for (int j = 7; j >= 0; j--) begin
              crc = crc16_bit(crc, exp_b[j]);
            end
          end
          get_byte(hi);
          get_byte(v);
          if ({hi, v} !== crc) begin
            val_err("crc16", {hi, v}, crc);
          end
        end
      end
    end
  endtask

  // miso stays high while cs is raised.
  task automatic abort_cs();
    @(negedge sck);
    cs = 1'b1;
    mosi = 1'b1;
    repeat (3) begin
      @(negedge sck);
      if (miso !== 1'b1) begin
        val_err("miso", miso, 1);
      end
    end
    cs = 1'b0;
  endtask

  initial begin
    logic [31:0] w;
    logic [31:0] s;
    logic [31:0] r;
    logic [7:0]  exp_r1;
    logic [7:0]  r1;
    logic [1:0]  kind;
    logic        found;
    logic        b;
    logic [5:0]  idx;
    int          a;
    rst = 1'b1;
    cs = 1'b1;
    mosi = 1'b1;
    req = '0;
    m_idle = 1'b1;
    m_app = 1'b0;
    m_seen = 1'b0;
    m_crc_errs = '0;
    m_reads = '0;
    repeat (4) @(posedge sck);
    @(negedge sck);
    rst = 1'b0;
    if (miso !== 1'b1) begin
      val_err("miso", miso, 1);
    end
    if (rsp.bvalid !== 1'b0 || rsp.rvalid !== 1'b0 || rsp.awready !== 1'b0 ||
        rsp.wready !== 1'b0 || rsp.arready !== 1'b0) begin
      other_err("bus outputs not idle after reset");
    end
    check_status();

    // 1. bus store with a full fill and a byte-merged overwrite.
    for (int i = 0; i < 512; i++) begin
      w = rand32();
      bus_write(12'(i * 4), w, 4'hF);
      m_mem[i] = w;
    end
    for (int i = 0; i < 512; i++) begin
      w = rand32();
      s = rand32();
      bus_write(12'(i * 4), w, s[3:0]);
      for (int k = 0; k < 4; k++) begin
        if (s[k]) begin
          m_mem[i][8*k +: 8] = w[8*k +: 8];
        end
      end
    end
    for (int i = 0; i < 64; i++) begin
      a = rand32() % 512;
      bus_read(12'(a * 4), r);
      if (r !== m_mem[a]) begin
        val_err("rdata", r, m_mem[a]);
      end
    end
    bus_write(status_addr, rand32(), 4'hF);
    check_status();

    // 2. init sequence.
    cs = 1'b0;
    for (int i = 0; i < 6; i++) begin
      w = (init_idx[i] == cmd8) ? (32'h0000_0100 | (rand32() & 32'hFF)) : 32'h4000_0000;
      run_cmd(init_idx[i], w, 1'b0);
      if (last_r1 !== init_r1[i]) begin
        val_err("init r1", last_r1, init_r1[i]);
      end
    end
    check_status();

    // 3. block reads.
    for (int i = 0; i < 6; i++) begin
      run_cmd(cmd17, rand32() % 4, 1'b0);
      check_status();
    end

    // 4. error cases.
    for (int i = 0; i < 3; i++) begin
      a = rand32() % 3;
      idx = (a == 0) ? cmd0 : ((a == 1) ? cmd8 : cmd17);
      run_cmd(idx, rand32() & 32'h3, 1'b1);
    end
    check_status();
    idx = rand32() % 64;
    if (idx == cmd0 || idx == cmd8 || idx == cmd17 || idx == cmd55) begin
      idx = 6'd63;
    end
    run_cmd(idx, rand32(), 1'b0);
    run_cmd(cmd17, rand32() | 32'h4, 1'b0);
    run_cmd(cmd0, 32'd0, 1'b0);
    run_cmd(cmd17, rand32() % 4, 1'b0);
    run_cmd(idx, rand32(), 1'b0);
    for (int i = 2; i < 6; i++) begin
      run_cmd(init_idx[i], 32'h4000_0000, 1'b0);
    end
    check_status();

    // 5. aborts mid-command and mid-block.
    send_frame(cmd0, 32'd0, 1'b0, 20);
    abort_cs();
    run_cmd(cmd8, 32'h0000_0100 | (rand32() & 32'hFF), 1'b0);
    w = rand32() % 4;
    model_cmd(cmd17, w, 1'b1, exp_r1, kind);
    send_frame(cmd17, w, 1'b0, 48);
    find_r1(r1, found);
    if (found && r1 !== exp_r1) begin
      val_err("r1", r1, exp_r1);
    end
    repeat (200) get_bit(b);
    abort_cs();
    run_cmd(cmd8, 32'h0000_0100 | (rand32() & 32'hFF), 1'b0);
    run_cmd(cmd17, rand32() % 4, 1'b0);
    check_status();

    report_and_finish();
  end

endmodule

// File: hw/sd_axil_regs.sv
`timescale 1ns/1ps

module sd_axil_regs (
  input  logic                      sck,
  input  logic                      rst,
  input  sd_pkg::axil_req_t         req,
  input  logic                      card_ready,
  input  logic [7:0]                crc_err_count,
  input  logic [15:0]               read_count,
  output sd_pkg::axil_rsp_t         rsp,
  output logic                      ram_wr_en,
  output logic [sd_pkg::ram_aw-1:0] ram_wr_addr,
  output logic [31:0]               ram_wr_data,
  output logic [3:0]                ram_wr_strb,
  output logic [sd_pkg::ram_aw-1:0] ram_rd_addr,
  input  logic [31:0]               ram_rd_data
);
  import sd_pkg::*;

  logic        bvalid_q;
  logic        rpend_q;
  logic        rvalid_q;
  logic        rd_ram_q;
  logic        rd_status_q;
  logic [31:0] rdata_q;
  logic [31:0] status_word;
  logic        wr_fire;
  logic        rd_fire;

  assign status_word = {read_count, crc_err_count, 7'd0, card_ready};

  // AW and W are taken together, one write at a time.
  assign wr_fire = req.awvalid && req.wvalid && !bvalid_q;
  assign rd_fire = req.arvalid && !rpend_q && !rvalid_q;

  assign ram_wr_en = wr_fire && (req.awaddr < status_addr);
  assign ram_wr_addr = req.awaddr[10:2];
  assign ram_wr_data = req.wdata;
  assign ram_wr_strb = req.wstrb;
  assign ram_rd_addr = req.araddr[10:2];

  always_comb begin
    rsp.awready = wr_fire;
    rsp.wready = wr_fire;
    rsp.bvalid = bvalid_q;
    rsp.bresp = 2'b00;
    rsp.arready = rd_fire;
    rsp.rvalid = rvalid_q;
    rsp.rdata = rdata_q;
    rsp.rresp = 2'b00;
  end

  always_ff @(posedge sck) begin
    if (rst) begin
      bvalid_q <= 1'b0;
      rpend_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (req.bready) begin
        bvalid_q <= 1'b0;
      end
      // one cycle for the store to answer.
      rpend_q <= rd_fire;
      if (rpend_q) begin
        rvalid_q <= 1'b1;
      end else if (req.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge sck) begin
    if (rd_fire) begin
      rd_ram_q <= (req.araddr < status_addr);
      rd_status_q <= (req.araddr == status_addr);
    end
    if (rpend_q) begin
      rdata_q <= rd_ram_q ? ram_rd_data : (rd_status_q ? status_word : 32'd0);
    end
  end

  assert property (@(posedge sck) disable iff (rst) bvalid_q && !req.bready |=> bvalid_q);

endmodule

// File: hw/sd_block_ram.sv
`timescale 1ns/1ps

module sd_block_ram (
  input  logic                      sck,
  input  logic                      wr_en,
  input  logic [sd_pkg::ram_aw-1:0] wr_addr,
  input  logic [31:0]               wr_data,
  input  logic [3:0]                wr_strb,
  input  logic [sd_pkg::ram_aw-1:0] rd_a_addr,
  input  logic [sd_pkg::ram_aw-1:0] rd_b_addr,
  output logic [31:0]               rd_a_data,
  output logic [31:0]               rd_b_data
);
  import sd_pkg::*;

  logic [31:0] mem [num_blocks * block_words];

  // byte lanes under wr_strb.
  always_ff @(posedge sck) begin
    if (wr_en) begin
      for (int i = 0; i < 4; i++) begin
        if (wr_strb[i]) begin
          mem[wr_addr][8*i +: 8] <= wr_data[8*i +: 8];
        end
      end
    end
  end

  // both read ports return old data on a collision.
  always_ff @(posedge sck) begin
    rd_a_data <= mem[rd_a_addr];
    rd_b_data <= mem[rd_b_addr];
  end

endmodule

// File: hw/sd_cmd_ctrl.sv
`timescale 1ns/1ps

module sd_cmd_ctrl (
  input  logic             sck,
  input  logic             rst,
  input  sd_pkg::sd_cmd_t  cmd,
  input  logic             cmd_valid,
  input  logic             tx_busy,
  output sd_pkg::sd_resp_t resp,
  output logic             resp_valid,
  output logic             card_ready,
  output logic [7:0]       crc_err_count,
  output logic [15:0]      read_count
);
  import sd_pkg::*;

  logic     idle_q;
  logic     app_cmd_q;
  logic     acmd41_seen_q;
  logic     idle_d;
  logic     app_cmd_d;
  logic     acmd41_seen_d;
  logic     issue;
  logic [7:0] idle_bit;
  sd_resp_t resp_d;

  assign idle_bit = {7'd0, idle_q};
  assign issue = cmd_valid && !tx_busy;
  assign card_ready = !idle_q;

  always_comb begin
    resp_d.kind = r1_only;
    resp_d.r1 = idle_bit;
    resp_d.tail = '0;
    resp_d.block = cmd.arg[1:0];
    idle_d = idle_q;
    app_cmd_d = 1'b0;
    acmd41_seen_d = acmd41_seen_q;
    if (!cmd.crc_ok) begin
      // bad frame leaves every flag as it was.
      resp_d.r1 = r1_crc_err | idle_bit;
      app_cmd_d = app_cmd_q;
    end else if (cmd.index == cmd0) begin
      idle_d = 1'b1;
      acmd41_seen_d = 1'b0;
      resp_d.r1 = r1_idle;
    end else if (cmd.index == cmd8) begin
      // voltage accepted, check pattern echoed.
      resp_d.kind = r7_tail;
      resp_d.tail = {20'd0, 4'h1, cmd.arg[7:0]};
    end else if (cmd.index == cmd55) begin
      app_cmd_d = 1'b1;
    end else if (cmd.index == cmd41 && app_cmd_q) begin
      if (!acmd41_seen_q) begin
        acmd41_seen_d = 1'b1;
        resp_d.r1 = r1_idle;
      end else begin
        idle_d = 1'b0;
        resp_d.r1 = 8'h00;
      end
    end else if (cmd.index == cmd17 && !idle_q) begin
      resp_d.r1 = 8'h00;
      resp_d.kind = (cmd.arg < 32'(num_blocks)) ? data_block : error_token;
    end else begin
      resp_d.r1 = r1_illegal | idle_bit;
    end
  end

  always_ff @(posedge sck) begin
    if (rst) begin
      idle_q <= 1'b1;
      app_cmd_q <= 1'b0;
      acmd41_seen_q <= 1'b0;
      resp_valid <= 1'b0;
      crc_err_count <= '0;
      read_count <= '0;
    end else begin
      resp_valid <= issue;
      if (issue) begin
        idle_q <= idle_d;
        app_cmd_q <= app_cmd_d;
        acmd41_seen_q <= acmd41_seen_d;
        if (!cmd.crc_ok && crc_err_count != 8'hFF) begin
          crc_err_count <= crc_err_count + 8'd1;
        end
        if (resp_d.kind == data_block) begin
          read_count <= read_count + 16'd1;
        end
      end
    end
  end

  always_ff @(posedge sck) begin
    if (issue) begin
      resp <= resp_d;
    end
  end

  // jobs only go out to an idle transmitter.
  assert property (@(posedge sck) disable iff (rst) resp_valid |-> !tx_busy);

endmodule

// File: hw/sd_cmd_rx.sv
`timescale 1ns/1ps

module sd_cmd_rx (
  input  logic            sck,
  input  logic            rst,
  input  logic            cs,
  input  logic            mosi,
  input  logic            tx_busy,
  output sd_pkg::sd_cmd_t cmd,
  output logic            cmd_valid
);
  import sd_pkg::*;

  logic [47:0] shift_q;
  logic [47:0] frame;
  logic [5:0]  cnt_q;
  logic        receiving_q;
  logic        frame_done;

  // the bit on mosi now completes the frame.
  assign frame = {shift_q[46:0], mosi};
  assign frame_done = receiving_q && !tx_busy && (cnt_q == 6'd47);

  always_ff @(posedge sck) begin
    if (rst || cs) begin
      receiving_q <= 1'b0;
      cnt_q <= '0;
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= 1'b0;
      if (!tx_busy) begin
        if (!receiving_q) begin
          // start bit.
          if (!mosi) begin
            receiving_q <= 1'b1;
            cnt_q <= 6'd1;
          end
        end else if (cnt_q == 6'd47) begin
          receiving_q <= 1'b0;
          cnt_q <= '0;
          // transmission bit and end bit must both be 1.
          cmd_valid <= frame[46] && frame[0];
        end else begin
          cnt_q <= cnt_q + 6'd1;
        end
      end
    end
  end

  always_ff @(posedge sck) begin
    if (!tx_busy) begin
      shift_q <= frame;
    end
    if (frame_done) begin
      cmd.index <= frame[45:40];
      cmd.arg <= frame[39:8];
      cmd.crc_ok <= (frame[7:1] == crc7_calc(frame[47:8]));
    end
  end

  // the card never sees a new command while it is still answering.
  assert property (@(posedge sck) disable iff (rst) cmd_valid |-> !tx_busy);

endmodule

// File: hw/sd_pkg.sv
package sd_pkg;

  // block store geometry.
  localparam int num_blocks = 4;
  localparam int block_words = 128;
  localparam int ram_aw = 9;
  localparam logic [11:0] status_addr = 12'h800;

  // command indexes.
  localparam logic [5:0] cmd0 = 6'd0;
  localparam logic [5:0] cmd8 = 6'd8;
  localparam logic [5:0] cmd17 = 6'd17;
  localparam logic [5:0] cmd41 = 6'd41;
  localparam logic [5:0] cmd55 = 6'd55;

  localparam logic [7:0] r1_idle = 8'h01;
  localparam logic [7:0] r1_illegal = 8'h04;
  localparam logic [7:0] r1_crc_err = 8'h08;
  localparam logic [7:0] tok_start = 8'hFE;
  localparam logic [7:0] tok_range_err = 8'h08;

  typedef struct packed {
    logic [5:0]  index;
    logic [31:0] arg;
    logic        crc_ok;
  } sd_cmd_t;

  typedef enum logic [1:0] {r1_only, r7_tail, data_block, error_token} resp_kind_t;

  typedef struct packed {
    resp_kind_t  kind;
    logic [7:0]  r1;
    logic [31:0] tail;
    logic [1:0]  block;
  } sd_resp_t;

  typedef struct packed {
    logic        awvalid;
    logic [11:0] awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bready;
    logic        arvalid;
    logic [11:0] araddr;
    logic        rready;
  } axil_req_t;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_rsp_t;

  // x^7 + x^3 + 1 over the first 40 bits of a command.
  function automatic logic [6:0] crc7_calc(input logic [39:0] data);
    logic [6:0] crc;
    logic fb;
    crc = '0;
    for (int i = 39; i >= 0; i--) begin
      fb = crc[6] ^ data[i];
      crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    end
    return crc;
  endfunction

  // x^16 + x^12 + x^5 + 1, one bit per call.
  function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic din);
    logic fb;
    fb = crc[15] ^ din;
    return {crc[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
  endfunction

endpackage

// File: hw/sd_resp_tx.sv
`timescale 1ns/1ps

module sd_resp_tx (
  input  logic                      sck,
  input  logic                      rst,
  input  logic                      cs,
  input  sd_pkg::sd_resp_t          resp,
  input  logic                      resp_valid,
  input  logic [31:0]               blk_rdata,
  output logic [sd_pkg::ram_aw-1:0] blk_raddr,
  output logic                      tx_busy,
  output logic                      miso
);
  import sd_pkg::*;

  typedef enum logic [1:0] {ph_idle, ph_hdr, ph_data, ph_crc} phase_t;

  phase_t      phase_q;
  logic [47:0] sh_q;
  logic [5:0]  cnt_q;
  logic [6:0]  word_q;
  logic [1:0]  block_q;
  logic        is_data_q;
  logic [15:0] crc_q;
  logic [15:0] crc_next;
  logic [31:0] word_ser;
  logic        word_end;

  assign crc_next = crc16_step(crc_q, sh_q[47]);
  // bytes leave in address order, each MSB first.
  assign word_ser = {blk_rdata[7:0], blk_rdata[15:8], blk_rdata[23:16], blk_rdata[31:24]};
  assign blk_raddr = {block_q, word_q};
  assign word_end = (cnt_q == 6'd0) && ((phase_q == ph_hdr && is_data_q) || phase_q == ph_data);
  assign tx_busy = (phase_q != ph_idle);
  assign miso = cs | sh_q[47];

  always_ff @(posedge sck) begin
    if (rst || cs) begin
      phase_q <= ph_idle;
      sh_q <= '1;
      cnt_q <= '0;
    end else if (phase_q == ph_idle) begin
      if (resp_valid) begin
        phase_q <= ph_hdr;
        // Ncr byte and R1 lead every header.
        case (resp.kind)
          r1_only: begin
            sh_q <= {8'hFF, resp.r1, 32'hFFFF_FFFF};
            cnt_q <= 6'd15;
          end
          r7_tail: begin
            sh_q <= {8'hFF, resp.r1, resp.tail};
            cnt_q <= 6'd47;
          end
          error_token: begin
            sh_q <= {8'hFF, resp.r1, 8'hFF, tok_range_err, 16'hFFFF};
            cnt_q <= 6'd31;
          end
          default: begin
            sh_q <= {8'hFF, resp.r1, 8'hFF, tok_start, 16'hFFFF};
            cnt_q <= 6'd31;
          end
        endcase
      end
    end else if (cnt_q != 6'd0) begin
      sh_q <= {sh_q[46:0], 1'b1};
      cnt_q <= cnt_q - 6'd1;
    end else if (word_end && !(phase_q == ph_data && word_q == 7'd0)) begin
      phase_q <= ph_data;
      sh_q <= {word_ser, 16'hFFFF};
      cnt_q <= 6'd31;
    end else if (phase_q == ph_data) begin
      // word counter wrapped, the block is out.
      phase_q <= ph_crc;
      sh_q <= {crc_next, 32'hFFFF_FFFF};
      cnt_q <= 6'd15;
    end else begin
      phase_q <= ph_idle;
      sh_q <= '1;
    end
  end

  always_ff @(posedge sck) begin
    if (phase_q == ph_idle) begin
      word_q <= '0;
      crc_q <= '0;
      block_q <= resp.block;
      is_data_q <= (resp.kind == data_block);
    end else begin
      if (word_end) begin
        word_q <= word_q + 7'd1;
      end
      if (phase_q == ph_data) begin
        crc_q <= crc_next;
      end
    end
  end

  assert property (@(posedge sck) disable iff (rst) !tx_busy |-> miso);

endmodule

// File: hw/sd_spi_card.sv
`timescale 1ns/1ps

module sd_spi_card (
  input  logic              sck,
  input  logic              rst,
  input  logic              cs,
  input  logic              mosi,
  output logic              miso,
  input  sd_pkg::axil_req_t axil_req,
  output sd_pkg::axil_rsp_t axil_rsp
);
  import sd_pkg::*;

  sd_cmd_t             cmd;
  logic                cmd_valid;
  sd_resp_t            resp;
  logic                resp_valid;
  logic                tx_busy;
  logic                card_ready;
  logic [7:0]          crc_err_count;
  logic [15:0]         read_count;
  logic [ram_aw-1:0]   blk_raddr;
  logic [31:0]         blk_rdata;
  logic                ram_wr_en;
  logic [ram_aw-1:0]   ram_wr_addr;
  logic [31:0]         ram_wr_data;
  logic [3:0]          ram_wr_strb;
  logic [ram_aw-1:0]   ram_rd_addr;
  logic [31:0]         ram_rd_data;

  sd_cmd_rx u_cmd_rx (
    .sck       (sck),
    .rst       (rst),
    .cs        (cs),
    .mosi      (mosi),
    .tx_busy   (tx_busy),
    .cmd       (cmd),
    .cmd_valid (cmd_valid)
  );

  sd_cmd_ctrl u_cmd_ctrl (
    .sck           (sck),
    .rst           (rst),
    .cmd           (cmd),
    .cmd_valid     (cmd_valid),
    .tx_busy       (tx_busy),
    .resp          (resp),
    .resp_valid    (resp_valid),
    .card_ready    (card_ready),
    .crc_err_count (crc_err_count),
    .read_count    (read_count)
  );

  sd_resp_tx u_resp_tx (
    .sck        (sck),
    .rst        (rst),
    .cs         (cs),
    .resp       (resp),
    .resp_valid (resp_valid),
    .blk_rdata  (blk_rdata),
    .blk_raddr  (blk_raddr),
    .tx_busy    (tx_busy),
    .miso       (miso)
  );

  // port a belongs to the bus, port b to the card.
  sd_block_ram u_block_ram (
    .sck       (sck),
    .wr_en     (ram_wr_en),
    .wr_addr   (ram_wr_addr),
    .wr_data   (ram_wr_data),
    .wr_strb   (ram_wr_strb),
    .rd_a_addr (ram_rd_addr),
    .rd_b_addr (blk_raddr),
    .rd_a_data (ram_rd_data),
    .rd_b_data (blk_rdata)
  );

  sd_axil_regs u_axil_regs (
    .sck           (sck),
    .rst           (rst),
    .req           (axil_req),
    .card_ready    (card_ready),
    .crc_err_count (crc_err_count),
    .read_count    (read_count),
    .rsp           (axil_rsp),
    .ram_wr_en     (ram_wr_en),
    .ram_wr_addr   (ram_wr_addr),
    .ram_wr_data   (ram_wr_data),
    .ram_wr_strb   (ram_wr_strb),
    .ram_rd_addr   (ram_rd_addr),
    .ram_rd_data   (ram_rd_data)
  );

endmodule
